/* hw/ucore_pkg.sv */
package ucore_pkg;

    // Field widths
    localparam int WORD_W     = 32;
    localparam int IDX_W      = 4;
    localparam int IMM_W      = 16;
    localparam int OPC_W      = 7;
    localparam int AXI_ADDR_W = 12;
    localparam int NUM_REGS   = 16;          // Architectural register count

    typedef logic [WORD_W-1:0]     word_t;     // Register contents and AXI data
    typedef logic [IDX_W-1:0]      reg_idx_t;  // Register index
    typedef logic [IMM_W-1:0]      imm_t;      // Immediate, also the multiply count
    typedef logic [OPC_W-1:0]      opcode_t;
    typedef logic [AXI_ADDR_W-1:0] axil_addr_t;

    // Instruction layout, LSB of each field
    localparam int OPC_LSB = 25;
    localparam int RD_LSB  = 21;
    localparam int RS1_LSB = 17;
    localparam int RS2_LSB = 13;             // Overlaps imm16, which sits in 15:0

    // Opcodes
    localparam opcode_t OP_NOP  = 7'b1100100; // 11001 in the top bits
    localparam opcode_t OP_MOVI = 7'b0000000;
    localparam opcode_t OP_ADD  = 7'b0110001;
    localparam opcode_t OP_SUB  = 7'b0110010;
    localparam opcode_t OP_MULI = 7'b0111000;
    localparam opcode_t OP_MULR = 7'b0111001;

    // Decoded micro-op, drives the execute unit
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
    } uop_t;

    localparam uop_t UOP_NOP = '{op: OP_NOP, rd: '0, rs1: '0, rs2: '0, imm: '0};

    // Multiply sequencer states
    typedef enum logic [2:0] {
        S_IDLE  = 3'd0,
        S_CLEAR = 3'd1,   // Zero count, single SUB rd,rd,rd
        S_MOV   = 3'd2,   // rd <- 0
        S_ADD   = 3'd3,   // rd <- rd + rs1, once per count
        S_HALT  = 3'd4    // One cycle to hand the pipeline back
    } seq_state_t;

    // AXI4-Lite register map
    localparam axil_addr_t ADDR_INSTR    = 12'h000; // Write only
    localparam axil_addr_t ADDR_STATUS   = 12'h004; // Bit 0 is busy
    localparam axil_addr_t ADDR_REG_BASE = 12'h040; // Register i at base + 4*i

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        axil_addr_t addr;
        logic       valid;
    } axil_aw_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       valid;
    } axil_w_t;

endpackage

/* hw/axil_host_port.sv */
`timescale 1ns/1ps

module axil_host_port
    import ucore_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axil_aw_t   aw,
    output logic       awready,
    input  axil_w_t    w,
    output logic       wready,
    output logic       bvalid,
    output logic [1:0] bresp,
    input  logic       bready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready,
    input  logic       busy,
    output logic       instr_valid,
    output word_t      instr,
    output reg_idx_t   host_raddr,
    input  word_t      host_rdata
);

    logic       live;                 // Low until the first cycle out of reset
    logic       aw_hold, w_hold;      // Channel already taken, waiting for its partner
    axil_addr_t aw_addr_q;
    word_t      w_data_q;
    logic [3:0] w_strb_q;
    logic       aw_take, w_take, wr_fire, wr_is_instr;
    axil_addr_t wr_addr;
    word_t      wr_data;
    logic [3:0] wr_strb;
    logic       ar_take, rd_is_status, rd_is_reg;

    // Write channels stall while the core is busy or a response is out
    assign awready = live & ~aw_hold & ~bvalid & ~busy;
    assign wready  = live & ~w_hold & ~bvalid & ~busy;
    assign aw_take = aw.valid & awready;
    assign w_take  = w.valid & wready;

    // Current beat or the held one
    assign wr_addr = aw_hold ? aw_addr_q : aw.addr;
    assign wr_data = w_hold ? w_data_q : w.data;
    assign wr_strb = w_hold ? w_strb_q : w.strb;
    assign wr_fire = (aw_hold | aw_take) & (w_hold | w_take);
    assign wr_is_instr = (wr_addr == ADDR_INSTR) && (wr_strb == 4'hF); // Full word only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live        <= 1'b0;
            aw_hold     <= 1'b0;
            w_hold      <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= RESP_OKAY;
            instr_valid <= 1'b0;
        end else begin
            live        <= 1'b1;
            instr_valid <= 1'b0;                 // Single-cycle pulse
            if (wr_fire) begin
                aw_hold     <= 1'b0;
                w_hold      <= 1'b0;
                bvalid      <= 1'b1;
                bresp       <= wr_is_instr ? RESP_OKAY : RESP_SLVERR;
                instr_valid <= wr_is_instr;      // Other addresses issue nothing
            end else begin
                if (aw_take) aw_hold <= 1'b1;
                if (w_take) w_hold <= 1'b1;
                if (bvalid && bready) bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_take) aw_addr_q <= aw.addr;
        if (w_take) begin
            w_data_q <= w.data;
            w_strb_q <= w.strb;
        end
        if (wr_fire) instr <= wr_data;
    end

    // Read side, one outstanding read
    assign arready = live & ~rvalid;
    assign ar_take = arvalid & arready;
    assign host_raddr   = araddr[2 +: IDX_W];  // Word index within the register window
    assign rd_is_status = (araddr == ADDR_STATUS);
    assign rd_is_reg    = ((araddr & ~axil_addr_t'(12'h03C)) == ADDR_REG_BASE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (ar_take) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_take) begin
            if (rd_is_status) begin
                rdata <= {{(WORD_W-1){1'b0}}, busy};
                rresp <= RESP_OKAY;
            end else if (rd_is_reg) begin
                rdata <= host_rdata;             // Value at the moment of the AR handshake
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import ucore_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  instr_valid,
    input  word_t instr,
    input  logic  seq_busy,
    output logic  dec_valid,
    output uop_t  dec_uop,
    output logic  mul_start,
    output uop_t  mul_uop,
    output logic  busy
);

    opcode_t opc;
    uop_t    fields;
    uop_t    uop_q;
    logic    is_mul, is_known;
    logic    pending;                       // Decoded word not yet handed on

    // Split the word, all fields extracted regardless of form
    always_comb begin
        opc        = instr[OPC_LSB +: OPC_W];
        fields.op  = opc;
        fields.rd  = instr[RD_LSB +: IDX_W];
        fields.rs1 = instr[RS1_LSB +: IDX_W];
        fields.rs2 = instr[RS2_LSB +: IDX_W];
        fields.imm = instr[IMM_W-1:0];
        is_mul     = (opc == OP_MULI) || (opc == OP_MULR);
        is_known   = is_mul || (opc == OP_NOP) || (opc == OP_MOVI) ||
                     (opc == OP_ADD) || (opc == OP_SUB);
        if (!is_known) fields = UOP_NOP;    // Unknown opcode degrades to NOP
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
            mul_start <= 1'b0;
        end else begin
            dec_valid <= instr_valid & ~is_mul;  // Straight to execute
            mul_start <= instr_valid & is_mul;   // Hand to the sequencer
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) uop_q <= fields;
    end

    assign dec_uop = uop_q;
    assign mul_uop = uop_q;   // Same register, qualified by mul_start
    assign pending = dec_valid | mul_start;
    assign busy    = instr_valid | pending | seq_busy;

endmodule

/* hw/mul_ucode_seq.sv */
`timescale 1ns/1ps

module mul_ucode_seq
    import ucore_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  mul_start,
    input  uop_t  mul_uop,
    input  word_t op_b_val,   // rs2 contents, read in the start cycle
    output uop_t  seq_uop,
    output logic  seq_own,
    output logic  seq_busy
);

    seq_state_t state, state_nxt;
    imm_t       cnt_q, cnt_nxt;      // ADDs still to issue
    imm_t       start_cnt;
    reg_idx_t   rd_q, rs1_q;
    logic       start;

    assign start = (state == S_IDLE) && mul_start;

    // MULI counts from imm16, MULR from the low half of rs2
    always_comb begin
        if (mul_uop.op == OP_MULR) begin
            start_cnt = op_b_val[IMM_W-1:0];
        end else begin
            start_cnt = mul_uop.imm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt_q <= '0;
        end else begin
            state <= state_nxt;
            cnt_q <= cnt_nxt;
        end
    end

    // Operand registers, loaded once per multiply
    always_ff @(posedge clk) begin
        if (start) begin
            rd_q  <= mul_uop.rd;
            rs1_q <= mul_uop.rs1;
        end
    end

    // Next state and micro-op emission
    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt_q;
        seq_uop   = UOP_NOP;
        seq_own   = 1'b0;
        case (state)
            S_IDLE: begin
                if (mul_start) begin
                    cnt_nxt   = start_cnt;
                    // x*0 takes the short path
                    state_nxt = (start_cnt == '0) ? S_CLEAR : S_MOV;
                end
            end
            S_CLEAR: begin
                seq_uop.op  = OP_SUB;       // rd - rd clears rd
                seq_uop.rd  = rd_q;
                seq_uop.rs1 = rd_q;
                seq_uop.rs2 = rd_q;
                seq_own     = 1'b1;
                state_nxt   = S_HALT;
            end
            S_MOV: begin
                seq_uop.op  = OP_MOVI;      // rd <- 0
                seq_uop.rd  = rd_q;
                seq_uop.imm = '0;
                seq_own     = 1'b1;
                state_nxt   = S_ADD;        // Count is at least one here
            end
            S_ADD: begin
                seq_uop.op  = OP_ADD;
                seq_uop.rd  = rd_q;
                seq_uop.rs1 = rd_q;         // Accumulator
                seq_uop.rs2 = rs1_q;
                seq_own     = 1'b1;
                cnt_nxt     = cnt_q - 1'b1;
                if (cnt_q == imm_t'(1)) state_nxt = S_HALT; // Last ADD
            end
            S_HALT: begin
                state_nxt = S_IDLE;         // Give the pipeline back
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    assign seq_busy = (state != S_IDLE);

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit
    import ucore_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     uop_valid,
    input  uop_t     uop,
    input  reg_idx_t op_b_raddr,   // Sequencer count read
    input  reg_idx_t host_raddr,   // Host read
    output word_t    op_b_val,
    output word_t    host_rdata
);

    word_t regs [NUM_REGS];
    word_t rs1_val, rs2_val;
    word_t result;
    logic  wr_en;

    assign rs1_val = regs[uop.rs1];
    assign rs2_val = regs[uop.rs2];

    // ALU, one micro-op per cycle
    always_comb begin
        result = '0;
        wr_en  = 1'b0;
        case (uop.op)
            OP_MOVI: begin
                result = {{(WORD_W-IMM_W){1'b0}}, uop.imm}; // Zero-extended
                wr_en  = uop_valid;
            end
            OP_ADD: begin
                result = rs1_val + rs2_val;      // Wraps mod 2^32
                wr_en  = uop_valid;
            end
            OP_SUB: begin
                result = rs1_val - rs2_val;
                wr_en  = uop_valid;
            end
            default: begin
                wr_en = 1'b0;                    // NOP, nothing written
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[uop.rd] <= result;
        end
    end

    // Asynchronous read ports
    assign op_b_val   = regs[op_b_raddr];
    assign host_rdata = regs[host_raddr];

endmodule

/* hw/ucore_top.sv */
`timescale 1ns/1ps

module ucore_top
    import ucore_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  axil_aw_t   aw,
    output logic       awready,
    input  axil_w_t    w,
    output logic       wready,
    output logic       bvalid,
    output logic [1:0] bresp,
    input  logic       bready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready
);

    logic     instr_valid, busy, dec_valid, mul_start, seq_own, seq_busy;
    word_t    instr, host_rdata, op_b_val;
    reg_idx_t host_raddr;
    uop_t     dec_uop, mul_uop, seq_uop, issue_uop;
    logic     issue_valid;

    axil_host_port u_host (
        .clk, .rst, .aw, .awready, .w, .wready, .bvalid, .bresp, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy, .instr_valid, .instr, .host_raddr, .host_rdata
    );

    instr_decoder u_dec (
        .clk, .rst, .instr_valid, .instr, .seq_busy,
        .dec_valid, .dec_uop, .mul_start, .mul_uop, .busy
    );

    mul_ucode_seq u_seq (
        .clk, .rst, .mul_start, .mul_uop, .op_b_val, .seq_uop, .seq_own, .seq_busy
    );

    // Issue mux, the sequencer wins while it owns the pipe
    assign issue_uop   = seq_own ? seq_uop : dec_uop;
    assign issue_valid = seq_own | dec_valid;

    exec_unit u_exec (
        .clk, .rst, .uop_valid(issue_valid), .uop(issue_uop),
        .op_b_raddr(mul_uop.rs2), .host_raddr, .op_b_val, .host_rdata
    );

endmodule

/* verif/ucore_chk.sv */
`timescale 1ns/1ps

module ucore_chk
    import ucore_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic awready,
    input logic busy,
    input logic seq_own,
    input logic seq_busy,   // High outside S_IDLE
    input logic bvalid,
    input logic bready,
    input logic mul_start,
    input uop_t mul_uop
);

    // No instruction write accepted while the core works
    a_aw_stall: assert property (@(posedge clk) disable iff (rst) busy |-> !awready)
        else $error("awready high while the core is busy");

    a_own_idle: assert property (@(posedge clk) disable iff (rst) !seq_busy |-> !seq_own)
        else $error("sequencer owns the pipeline while idle");

    a_b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // rd == rs1 would overwrite the multiplicand
    a_mul_rd: assert property (@(posedge clk) disable iff (rst)
                               mul_start |-> mul_uop.rd != mul_uop.rs1)
        else $error("multiply issued with rd equal to rs1");

endmodule

bind ucore_top ucore_chk u_chk (
    .clk, .rst, .awready, .busy, .seq_own, .seq_busy, .bvalid, .bready, .mul_start, .mul_uop
);

/* verif/ucore_tb.sv */
`timescale 1ns/1ps

module ucore_tb
    import ucore_pkg::*;
();

    localparam int          CLK_PERIOD = 100;
    localparam int          RST_CYCLES = 16;
    localparam int          MAX_CNT    = 40;            // Largest multiply count in the table
    localparam int          NUM_TESTS  = 20;
    localparam logic [31:0] SEED       = 32'hd516_ce7f;
    localparam axil_addr_t  BAD_ADDR   = 12'h008;       // Unmapped write address

    // How an entry is applied
    typedef enum int {K_PLAIN, K_CHAIN, K_RD_BUSY, K_BAD_WR} kind_t;

    logic       clk, rst, bready, arvalid, rready;
    logic       awready, wready, bvalid, arready, rvalid;
    logic [1:0] bresp, rresp;
    axil_aw_t   aw;
    axil_w_t    w;
    axil_addr_t araddr;
    word_t      rdata;

    // Stimulus table
    string    tbl_name  [NUM_TESTS];
    kind_t    tbl_kind  [NUM_TESTS];
    word_t    tbl_instr [NUM_TESTS];
    reg_idx_t tbl_chk   [NUM_TESTS];   // Register read back afterwards
    bit       tbl_model [NUM_TESTS];   // Expected value comes from the model
    word_t    tbl_exp   [NUM_TESTS];   // Literal expected value otherwise
    int       n_tbl, n_pass, n_fail;
    word_t    model [NUM_REGS];        // Architectural register state

    ucore_top i_dut (
        .clk, .rst, .aw, .awready, .w, .wready, .bvalid, .bresp, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic word_t encode(input opcode_t op, input int rd, input int rs1,
                                     input int rs2, input int imm);
        word_t iw;
        iw = {op, rd[3:0], rs1[3:0], 17'd0};
        if (op == OP_MOVI || op == OP_MULI) begin
            iw[15:0] = imm[15:0];              // imm16 forms
        end else begin
            iw[16:13] = rs2[3:0];
        end
        return iw;
    endfunction

    function automatic axil_addr_t reg_addr(input int idx);
        return ADDR_REG_BASE + axil_addr_t'(idx * 4);
    endfunction

    // ISA rules, products wrap mod 2^32
    function automatic void model_step(input word_t iw);
        opcode_t  op;
        reg_idx_t rd, rs1, rs2;
        imm_t     imm;
        op  = iw[31:25];
        rd  = iw[24:21];
        rs1 = iw[20:17];
        rs2 = iw[16:13];
        imm = iw[15:0];
        case (op)
            OP_MOVI: model[rd] = {16'h0, imm};                     // Zero-extended
            OP_ADD:  model[rd] = model[rs1] + model[rs2];
            OP_SUB:  model[rd] = model[rs1] - model[rs2];
            OP_MULI: model[rd] = model[rs1] * {16'h0, imm};
            OP_MULR: model[rd] = model[rs1] * {16'h0, model[rs2][15:0]}; // Old rs2 if rd==rs2
            default: ;
        endcase
    endfunction

    task automatic check_eq(input string name, input word_t exp, input word_t act);
        if (exp === act) begin
            n_pass++;
            $display("[PASS] %s = 0x%08h", name, act);
        end else begin
            n_fail++;
            $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    // AW and W go out together, so both readies rise in the same cycle
    task automatic axi_write(input axil_addr_t addr, input word_t data, output logic [1:0] resp);
        bit taken;
        @(posedge clk);
        aw.addr  <= addr;
        aw.valid <= 1'b1;
        w.data   <= data;
        w.strb   <= 4'hF;
        w.valid  <= 1'b1;
        bready   <= 1'b1;
        do begin
            @(negedge clk);
            taken = awready && wready;          // Accepted on the coming edge
            @(posedge clk);
        end while (!taken);
        aw.valid <= 1'b0;
        w.valid  <= 1'b0;
        do begin
            @(negedge clk);
        end while (!bvalid);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr, output word_t data, output logic [1:0] resp);
        bit taken;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do begin
            @(negedge clk);
            taken = arready;
            @(posedge clk);
        end while (!taken);
        arvalid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rvalid);
        data = rdata;                           // Stable mid-cycle
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic wait_idle();
        word_t      st;
        logic [1:0] resp;
        do begin
            axi_read(ADDR_STATUS, st, resp);
        end while (st[0]);                      // Bit 0 is busy
    endtask

    task automatic add_test(input string name, input kind_t kind, input word_t iw,
                            input int chk, input bit use_model, input word_t exp);
        tbl_name[n_tbl]  = name;
        tbl_kind[n_tbl]  = kind;
        tbl_instr[n_tbl] = iw;
        tbl_chk[n_tbl]   = chk[3:0];
        tbl_model[n_tbl] = use_model;
        tbl_exp[n_tbl]   = exp;
        n_tbl++;
    endtask

    task automatic fill_table();
        imm_t a, b, c, rcnt;
        a    = imm_t'(1 + $urandom % 16'hFFFE);   // Below 0xFFFF so the SUB wraps
        b    = imm_t'($urandom);
        c    = imm_t'(1 + $urandom % MAX_CNT);    // MULR count
        rcnt = imm_t'(3 + $urandom % (MAX_CNT - 2));
        add_test("movi_r1", K_PLAIN, encode(OP_MOVI, 1, 0, 0, a), 1, 1'b1, '0);
        add_test("movi_r2", K_PLAIN, encode(OP_MOVI, 2, 0, 0, b), 2, 1'b1, '0);
        add_test("movi_ffff", K_PLAIN, encode(OP_MOVI, 5, 0, 0, 'hFFFF), 5, 1'b0, 'hFFFF);
        add_test("add_r3", K_PLAIN, encode(OP_ADD, 3, 1, 2, 0), 3, 1'b1, '0);
        add_test("sub_wrap", K_PLAIN, encode(OP_SUB, 4, 1, 5, 0), 4, 1'b1, '0);
        add_test("add_wrap", K_PLAIN, encode(OP_ADD, 6, 4, 4, 0), 6, 1'b1, '0);
        add_test("muli_cnt0", K_PLAIN, encode(OP_MULI, 4, 1, 0, 0), 4, 1'b0, '0); // r4 held data
        add_test("muli_cnt1", K_PLAIN, encode(OP_MULI, 7, 2, 0, 1), 7, 1'b1, '0);
        add_test("muli_cnt2", K_PLAIN, encode(OP_MULI, 8, 6, 0, 2), 8, 1'b1, '0);
        add_test("muli_rand", K_PLAIN, encode(OP_MULI, 9, 6, 0, rcnt), 9, 1'b1, '0);
        add_test("movi_r11", K_PLAIN, encode(OP_MOVI, 11, 0, 0, 'h8000), 11, 1'b0, 'h8000);
        add_test("add_r12", K_PLAIN, encode(OP_ADD, 12, 11, 11, 0), 12, 1'b0, 'h1_0000);
        add_test("movi_r10", K_PLAIN, encode(OP_MOVI, 10, 0, 0, c), 10, 1'b1, '0);
        add_test("add_r10", K_PLAIN, encode(OP_ADD, 10, 10, 12, 0), 10, 1'b1, '0); // Bit 16 set
        add_test("mulr_hi", K_PLAIN, encode(OP_MULR, 13, 2, 10, 0), 13, 1'b1, '0);
        add_test("mulr_self", K_PLAIN, encode(OP_MULR, 10, 1, 10, 0), 10, 1'b1, '0);
        add_test("muli_chain", K_CHAIN, encode(OP_MULI, 14, 1, 0, MAX_CNT), 14, 1'b1, '0);
        add_test("add_after", K_PLAIN, encode(OP_ADD, 15, 14, 2, 0), 15, 1'b1, '0); // Stalled
        add_test("muli_busy_rd", K_RD_BUSY, encode(OP_MULI, 3, 2, 0, MAX_CNT), 12, 1'b1, '0);
        add_test("bad_addr", K_BAD_WR, encode(OP_MOVI, 0, 0, 0, 'h1234), 0, 1'b1, '0);
    endtask

    initial begin
        word_t      val;
        logic [1:0] resp;
        clk     = 1'b0;
        rst     = 1'b1;
        aw      = '0;
        w       = '0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        n_tbl   = 0;
        n_pass  = 0;
        n_fail  = 0;
        void'($urandom(SEED));
        for (int r = 0; r < NUM_REGS; r++) begin
            model[r] = '0;                      // Registers come out of reset at zero
        end
        fill_table();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_tbl; i++) begin
            if (tbl_kind[i] == K_BAD_WR) begin
                axi_write(BAD_ADDR, tbl_instr[i], resp);
                check_eq({tbl_name[i], "_bresp"}, word_t'(RESP_SLVERR), word_t'(resp));
                for (int r = 0; r < NUM_REGS; r++) begin
                    axi_read(reg_addr(r), val, resp);
                    check_eq($sformatf("%s_r%0d", tbl_name[i], r), model[r], val);
                end
            end else begin
                axi_write(ADDR_INSTR, tbl_instr[i], resp);
                model_step(tbl_instr[i]);
                if (tbl_kind[i] == K_RD_BUSY) begin
                    axi_read(ADDR_STATUS, val, resp);
                    check_eq({tbl_name[i], "_status"}, 32'd1, val);   // Still multiplying
                    axi_read(reg_addr(tbl_chk[i]), val, resp);
                    check_eq({tbl_name[i], "_during"}, model[tbl_chk[i]], val);
                end
                if (tbl_kind[i] != K_CHAIN) begin   // A chained entry runs into the next
                    wait_idle();
                    axi_read(reg_addr(tbl_chk[i]), val, resp);
                    check_eq(tbl_name[i], tbl_model[i] ? model[tbl_chk[i]] : tbl_exp[i], val);
                    check_eq({tbl_name[i], "_rresp"}, word_t'(RESP_OKAY), word_t'(resp));
                end
            end
        end
        $display("Summary: %0d checks passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Budget per entry is the longest multiply plus margin, then reset and the full readback
    initial begin
        #(longint'(NUM_TESTS * (MAX_CNT + 20) + RST_CYCLES + 5 * NUM_REGS) * CLK_PERIOD);
        $display("Timeout: the run did not finish within the watchdog limit");
        $display("Test failures found");
        $finish;
    end

endmodule

/* ucore.f */
hw/ucore_pkg.sv
hw/axil_host_port.sv
hw/instr_decoder.sv
hw/mul_ucode_seq.sv
hw/exec_unit.sv
hw/ucore_top.sv
verif/ucore_chk.sv
verif/ucore_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ucore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ucore_tb -Mdir obj_dir -f ucore.f

./obj_dir/Vucore_tb | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi

echo "Simulation passed"
